// ==== design/vdp_defines.svh ====
// Frame geometry, tile size and VRAM address width macros
`ifndef VDP_DEFINES_SVH
`define VDP_DEFINES_SVH

// ---------------------------------------------------------------------
// Frame geometry, shrunk to keep simulation short
// ---------------------------------------------------------------------
// Visible area
`define VDP_ACT_W 64
`define VDP_ACT_H 32
// Totals including blanking
`define VDP_H_TOTAL 80
`define VDP_V_TOTAL 40

// Tile edge, both directions
`define VDP_TILE 8

// 4 KB of VRAM
`define VDP_VRAM_AW 12
// Wide enough for both beam totals
`define VDP_CNT_W 7

`endif

// ==== design/vdp_cpu_pkg.sv ====
// Host command encoding, register indices and the display register set
`default_nettype none

package vdp_cpu_pkg;
  `include "vdp_defines.svh"

  // Host operations
  typedef enum logic [1:0] {
    OP_REG_WR,
    OP_VRAM_WR,
    OP_VRAM_RD,
    OP_STATUS_RD
  } cpu_op_t;

  // Register numbers
  typedef enum logic [1:0] {
    REG_CTRL,   // bit 0 display enable, bit 1 interrupt enable
    REG_NTB,    // name table base, units of 64 bytes
    REG_PAT,    // pattern table base, units of 2 KB
    REG_COL     // color table base high nibble, backdrop low nibble
  } reg_idx_t;

  // Command word held stable by the host for the whole handshake
  typedef struct packed {
    cpu_op_t                 op;
    reg_idx_t                index;
    logic [`VDP_VRAM_AW-1:0] addr;
    logic [7:0]              data;
  } cpu_cmd_t;

  typedef struct packed {
    logic [7:0] ctrl;
    logic [7:0] ntb;
    logic [7:0] pat;
    logic [7:0] col;
  } vdp_regs_t;

endpackage

`default_nettype wire

// ==== design/vdp_video_pkg.sv ====
// Beam position, VRAM read request and output pixel types
`default_nettype none

package vdp_video_pkg;
  `include "vdp_defines.svh"

  // Beam counter value
  typedef logic [`VDP_CNT_W-1:0] cnt_t;

  // ---------------------------------------------------------------------
  // Beam state, one value per pixel period
  // ---------------------------------------------------------------------
  typedef struct packed {
    cnt_t x;
    cnt_t y;
    logic active;      // inside the visible area
    logic frame_end;   // last pixel of the frame
  } beam_t;

  // Read request into the VRAM arbiter
  // Host side also uses it, with the strobe meaning a read
  typedef struct packed {
    logic [`VDP_VRAM_AW-1:0] addr;
    logic                    rd;
  } vram_req_t;

  // ---------------------------------------------------------------------
  // Output pixel, carries its own position
  // ---------------------------------------------------------------------
  typedef struct packed {
    logic       valid;   // one clock per pixel
    cnt_t       x;
    cnt_t       y;
    logic [3:0] col;     // TMS9918 palette index
    logic       blank;
  } pixel_t;

endpackage

`default_nettype wire

// ==== design/vdp_cpu_port.sv ====
// Host command port with req/ack handshake, display registers and frame interrupt
`timescale 1ns/100ps
`default_nettype none

module vdp_cpu_port
  import vdp_cpu_pkg::*;
  import vdp_video_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       reset_i,
  // Host side
  input  wire logic       cpu_req_i,
  input  wire cpu_cmd_t   cpu_cmd_i,
  output logic            cpu_ack_o,
  output logic [7:0]      cpu_rdata_o,
  // From beam timing
  input  wire logic       frame_end_i,
  // VRAM host channel
  output vram_req_t       host_req_o,
  output logic            host_we_o,
  output logic [7:0]      host_wdata_o,
  input  wire logic       host_gnt_i,
  input  wire logic [7:0] vram_rdata_i,
  // Register set and interrupt
  output vdp_regs_t       regs_o,
  output logic            int_n_o
);

  typedef enum logic [2:0] {S_IDLE, S_ACCESS, S_WAIT, S_ACK, S_RELEASE} port_state_t;

  port_state_t state_q;
  vdp_regs_t   regs_q;
  logic [7:0]  rdata_q;
  logic        frame_flag_q;
  logic        frame_end_q;
  logic        is_vram;
  logic        in_access;
  logic        status_clr;

  assign is_vram    = (cpu_cmd_i.op == OP_VRAM_WR) || (cpu_cmd_i.op == OP_VRAM_RD);
  assign in_access  = (state_q == S_ACCESS);
  assign status_clr = in_access && (cpu_cmd_i.op == OP_STATUS_RD);

  // ---------------------------------------------------------------------
  // Handshake FSM
  // ---------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= S_IDLE;
    end else begin
      case (state_q)
        // Release also takes a request raised right after ack fell
        S_IDLE, S_RELEASE: state_q <= cpu_req_i ? S_ACCESS : S_IDLE;
        S_ACCESS: begin
          if (!is_vram) begin
            state_q <= S_ACK;
          end else if (host_gnt_i) begin
            state_q <= (cpu_cmd_i.op == OP_VRAM_RD) ? S_WAIT : S_ACK;
          end
        end
        // VRAM read data lands here
        S_WAIT:  state_q <= S_ACK;
        S_ACK:   if (!cpu_req_i) state_q <= S_RELEASE;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // Register writes
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      regs_q <= '0;
    end else if (in_access && cpu_cmd_i.op == OP_REG_WR) begin
      case (cpu_cmd_i.index)
        REG_CTRL: regs_q.ctrl <= cpu_cmd_i.data;
        REG_NTB:  regs_q.ntb  <= cpu_cmd_i.data;
        REG_PAT:  regs_q.pat  <= cpu_cmd_i.data;
        default:  regs_q.col  <= cpu_cmd_i.data;
      endcase
    end
  end

  // Read data, status byte or VRAM byte
  always_ff @(posedge clk_i) begin
    if (status_clr) begin
      rdata_q <= {frame_flag_q, 7'b0};
    end else if (state_q == S_WAIT) begin
      rdata_q <= vram_rdata_i;
    end
  end

  // Frame flag sets on the first clock of frame_end, status read clears
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      frame_end_q  <= 1'b0;
      frame_flag_q <= 1'b0;
    end else begin
      frame_end_q <= frame_end_i;
      if (frame_end_i && !frame_end_q) begin
        frame_flag_q <= 1'b1;
      end else if (status_clr) begin
        frame_flag_q <= 1'b0;
      end
    end
  end

  // Host VRAM request held in ACCESS until granted
  assign host_req_o.addr = cpu_cmd_i.addr;
  assign host_req_o.rd   = in_access && (cpu_cmd_i.op == OP_VRAM_RD);
  assign host_we_o       = in_access && (cpu_cmd_i.op == OP_VRAM_WR);
  assign host_wdata_o    = cpu_cmd_i.data;

  assign cpu_ack_o   = (state_q == S_ACK);
  assign cpu_rdata_o = rdata_q;
  assign regs_o      = regs_q;
  assign int_n_o     = ~(frame_flag_q & regs_q.ctrl[1]);

endmodule

`default_nettype wire

// ==== design/vdp_timing.sv ====
// Pixel enable divider and horizontal/vertical beam counters
`timescale 1ns/100ps
`default_nettype none
`include "vdp_defines.svh"

module vdp_timing
  import vdp_video_pkg::*;
(
  input  wire logic clk_i,
  input  wire logic reset_i,
  output logic      pix_en_o,
  output beam_t     beam_o
);

  localparam cnt_t H_LAST = cnt_t'(`VDP_H_TOTAL - 1);
  localparam cnt_t V_LAST = cnt_t'(`VDP_V_TOTAL - 1);

  logic pix_en_q;
  cnt_t h_cnt_q;
  cnt_t v_cnt_q;

  // ---------------------------------------------------------------------
  // Pixel rate is clk_i / 2
  // ---------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pix_en_q <= 1'b0;
    end else begin
      pix_en_q <= ~pix_en_q;
    end
  end

  // Beam counters step on the enable clock
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      h_cnt_q <= '0;
      v_cnt_q <= '0;
    end else if (pix_en_q) begin
      if (h_cnt_q == H_LAST) begin
        h_cnt_q <= '0;
        // Wrap to line 0 after the last blank line
        v_cnt_q <= (v_cnt_q == V_LAST) ? '0 : v_cnt_q + 1'b1;
      end else begin
        h_cnt_q <= h_cnt_q + 1'b1;
      end
    end
  end

  assign pix_en_o = pix_en_q;

  // Area and frame markers decoded from the counters
  assign beam_o.x         = h_cnt_q;
  assign beam_o.y         = v_cnt_q;
  assign beam_o.active    = (h_cnt_q < cnt_t'(`VDP_ACT_W)) && (v_cnt_q < cnt_t'(`VDP_ACT_H));
  assign beam_o.frame_end = (h_cnt_q == H_LAST) && (v_cnt_q == V_LAST);

endmodule

`default_nettype wire

// ==== design/vdp_vram.sv ====
// Single-port VRAM with display-first arbitration of host accesses
`timescale 1ns/100ps
`default_nettype none
`include "vdp_defines.svh"

module vdp_vram
  import vdp_video_pkg::*;
(
  input  wire logic       clk_i,
  // Display fetch, always served
  input  wire vram_req_t  disp_req_i,
  // Host access, fills the free cycles
  input  wire vram_req_t  host_req_i,
  input  wire logic       host_we_i,
  input  wire logic [7:0] host_wdata_i,
  output logic            host_gnt_o,
  // Read data, one clock after the access
  output logic [7:0]      rdata_o
);

  localparam int DEPTH = 1 << `VDP_VRAM_AW;

  logic [7:0]              mem [DEPTH];
  logic [`VDP_VRAM_AW-1:0] addr;
  logic                    host_act;

  // ---------------------------------------------------------------------
  // Fixed priority arbiter
  // ---------------------------------------------------------------------
  assign host_act = host_req_i.rd | host_we_i;

  // Host only in cycles without a display read
  assign host_gnt_o = host_act & ~disp_req_i.rd;

  // Single address port
  assign addr = disp_req_i.rd ? disp_req_i.addr : host_req_i.addr;

  // ---------------------------------------------------------------------
  // Array
  // ---------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (host_gnt_o && host_we_i) begin
      mem[addr] <= host_wdata_i;
    end
    // Read every clock, users pick the cycle they need
    rdata_o <= mem[addr];
  end

endmodule

`default_nettype wire

// ==== design/vdp_delay_line.sv ====
// Enable-gated shift line for an arbitrary payload type
`timescale 1ns/100ps
`default_nettype none

module vdp_delay_line #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 1
) (
  input  wire logic     clk_i,
  input  wire logic     reset_i,
  input  wire logic     en_i,
  input  wire payload_t d_i,
  output payload_t      q_o
);

  payload_t stage_q [DEPTH];

  // Advance one slot per enable, oldest entry at the end
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage_q[i] <= '0;
      end
    end else if (en_i) begin
      stage_q[0] <= d_i;
      for (int i = 1; i < DEPTH; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign q_o = stage_q[DEPTH-1];

endmodule

`default_nettype wire

// ==== design/vdp_pattern.sv ====
// Tile fetch FSM, staging registers and pixel pattern shifter
`timescale 1ns/100ps
`default_nettype none
`include "vdp_defines.svh"

module vdp_pattern
  import vdp_cpu_pkg::*;
  import vdp_video_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       reset_i,
  input  wire logic       pix_en_i,
  input  wire beam_t      beam_i,
  input  wire vdp_regs_t  regs_i,
  // Display VRAM port
  output vram_req_t       vram_req_o,
  input  wire logic [7:0] vram_rdata_i,
  // Towards the color mux
  output beam_t           beam_o,
  output logic            pat_bit_o,
  output logic [3:0]      fg_o,
  output logic [3:0]      bg_o
);

  localparam cnt_t LAST_SLOT = cnt_t'(`VDP_H_TOTAL / `VDP_TILE - 1);
  localparam cnt_t V_LAST    = cnt_t'(`VDP_V_TOTAL - 1);

  typedef enum logic [2:0] {F_IDLE, F_NAME, F_PAT, F_COL, F_LAST} fetch_state_t;

  fetch_state_t state_q;
  beam_t        beam_d;
  logic         slot_start;
  logic         tile_end;
  cnt_t         next_line;
  logic [2:0]   tgt_col_q;
  logic [5:0]   tgt_line_q;
  logic [7:0]   name_q;
  logic [7:0]   pat_stage_q;
  logic [7:0]   col_stage_q;
  logic [7:0]   shift_q;
  logic [3:0]   fg_q;
  logic [3:0]   bg_q;

  // Beam lined up with the shifter output
  vdp_delay_line #(
    .payload_t(beam_t),
    .DEPTH    (8)
  ) beam_dly_b (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .en_i   (pix_en_i),
    .d_i    (beam_i),
    .q_o    (beam_d)
  );

  // First and last pixel of a tile slot
  assign slot_start = pix_en_i && (beam_d.x[2:0] == 3'd0);
  assign tile_end   = pix_en_i && (beam_d.x[2:0] == 3'd7);
  assign next_line  = (beam_d.y == V_LAST) ? '0 : beam_d.y + 1'b1;

  // ---------------------------------------------------------------------
  // Fetch FSM, name then pattern then color, back to back
  // ---------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= F_IDLE;
    end else begin
      case (state_q)
        F_IDLE:  if (slot_start) state_q <= F_NAME;
        F_NAME:  state_q <= F_PAT;
        F_PAT:   state_q <= F_COL;
        F_COL:   state_q <= F_LAST;
        default: state_q <= F_IDLE;
      endcase
    end
  end

  // Target is the next tile, column 0 of the next line from the last slot
  always_ff @(posedge clk_i) begin
    if (state_q == F_IDLE && slot_start) begin
      if (beam_d.x / cnt_t'(`VDP_TILE) == LAST_SLOT) begin
        tgt_col_q  <= 3'd0;
        tgt_line_q <= next_line[5:0];
      end else begin
        tgt_col_q  <= beam_d.x[5:3] + 3'd1;
        tgt_line_q <= beam_d.y[5:0];
      end
    end
    // Each byte arrives one clock after its read
    if (state_q == F_PAT)  name_q      <= vram_rdata_i;
    if (state_q == F_COL)  pat_stage_q <= vram_rdata_i;
    if (state_q == F_LAST) col_stage_q <= vram_rdata_i;
  end

  // Table addresses; the pattern read takes the name straight off the bus
  always_comb begin
    vram_req_o.rd   = 1'b0;
    vram_req_o.addr = '0;
    case (state_q)
      F_NAME: begin
        vram_req_o.rd   = 1'b1;
        vram_req_o.addr = {regs_i.ntb[5:0], tgt_line_q[5:3], tgt_col_q};
      end
      F_PAT: begin
        vram_req_o.rd   = 1'b1;
        vram_req_o.addr = {regs_i.pat[0], vram_rdata_i, tgt_line_q[2:0]};
      end
      F_COL: begin
        vram_req_o.rd   = 1'b1;
        vram_req_o.addr = {regs_i.col[7:4], 3'b000, name_q[7:3]};
      end
      default: ;
    endcase
  end

  // ---------------------------------------------------------------------
  // Pattern shifter, MSB is the leftmost pixel
  // ---------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      shift_q <= '0;
      fg_q    <= '0;
      bg_q    <= '0;
    end else if (tile_end) begin
      shift_q <= pat_stage_q;
      fg_q    <= col_stage_q[7:4];
      bg_q    <= col_stage_q[3:0];
    end else if (pix_en_i) begin
      shift_q <= {shift_q[6:0], 1'b0};
    end
  end

  assign beam_o    = beam_d;
  assign pat_bit_o = shift_q[7];
  assign fg_o      = fg_q;
  assign bg_o      = bg_q;

endmodule

`default_nettype wire

// ==== design/vdp_col_mux.sv ====
// Foreground, background and backdrop color selection with blanking
`timescale 1ns/100ps
`default_nettype none

module vdp_col_mux
  import vdp_cpu_pkg::*;
  import vdp_video_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       reset_i,
  input  wire logic       pix_en_i,
  input  wire beam_t      beam_i,
  input  wire vdp_regs_t  regs_i,
  input  wire logic       pat_bit_i,
  input  wire logic [3:0] fg_i,
  input  wire logic [3:0] bg_i,
  output pixel_t          pixel_o
);

  pixel_t     pix_d;
  logic [3:0] sel_col;

  // Tile color, transparent 0 falls through to the backdrop
  assign sel_col = pat_bit_i ? fg_i : bg_i;

  always_comb begin
    pix_d.valid = pix_en_i;
    pix_d.x     = beam_i.x;
    pix_d.y     = beam_i.y;
    pix_d.blank = ~beam_i.active;
    if (!beam_i.active) begin
      pix_d.col = 4'h0;
    end else if (!regs_i.ctrl[0]) begin
      pix_d.col = regs_i.col[3:0];
    end else begin
      pix_d.col = (sel_col == 4'h0) ? regs_i.col[3:0] : sel_col;
    end
  end

  // Output register, valid is a one-clock strobe per pixel
  vdp_delay_line #(
    .payload_t(pixel_t),
    .DEPTH    (1)
  ) out_reg_b (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .en_i   (1'b1),
    .d_i    (pix_d),
    .q_o    (pixel_o)
  );

endmodule

`default_nettype wire

// ==== design/vdp_core.sv ====
// Core top level connecting host port, timing, VRAM, pattern fetch and color mux
`timescale 1ns/100ps
`default_nettype none

module vdp_core
  import vdp_cpu_pkg::*;
  import vdp_video_pkg::*;
(
  // Global
  input  wire logic     clk_i,
  input  wire logic     reset_i,
  // Host command port
  input  wire logic     cpu_req_i,
  input  wire cpu_cmd_t cpu_cmd_i,
  output logic          cpu_ack_o,
  output logic [7:0]    cpu_rdata_o,
  output logic          int_n_o,
  // Video
  output pixel_t        pixel_o
);

  vdp_regs_t  regs;
  beam_t      beam_raw;
  beam_t      beam_pat;
  logic       pix_en;
  vram_req_t  disp_req;
  vram_req_t  host_req;
  logic       host_we;
  logic [7:0] host_wdata;
  logic       host_gnt;
  logic [7:0] vram_rdata;
  logic       pat_bit;
  logic [3:0] fg;
  logic [3:0] bg;

  // ---------------------------------------------------------------------
  // Host port
  // ---------------------------------------------------------------------
  vdp_cpu_port cpu_port_b (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cpu_req_i   (cpu_req_i),
    .cpu_cmd_i   (cpu_cmd_i),
    .cpu_ack_o   (cpu_ack_o),
    .cpu_rdata_o (cpu_rdata_o),
    .frame_end_i (beam_raw.frame_end),
    .host_req_o  (host_req),
    .host_we_o   (host_we),
    .host_wdata_o(host_wdata),
    .host_gnt_i  (host_gnt),
    .vram_rdata_i(vram_rdata),
    .regs_o      (regs),
    .int_n_o     (int_n_o)
  );

  // ---------------------------------------------------------------------
  // Beam timing and VRAM
  // ---------------------------------------------------------------------
  vdp_timing timing_b (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .pix_en_o(pix_en),
    .beam_o  (beam_raw)
  );

  vdp_vram vram_b (
    .clk_i       (clk_i),
    .disp_req_i  (disp_req),
    .host_req_i  (host_req),
    .host_we_i   (host_we),
    .host_wdata_i(host_wdata),
    .host_gnt_o  (host_gnt),
    .rdata_o     (vram_rdata)
  );

  // ---------------------------------------------------------------------
  // Pattern fetch and color output
  // ---------------------------------------------------------------------
  vdp_pattern pattern_b (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .pix_en_i    (pix_en),
    .beam_i      (beam_raw),
    .regs_i      (regs),
    .vram_req_o  (disp_req),
    .vram_rdata_i(vram_rdata),
    .beam_o      (beam_pat),
    .pat_bit_o   (pat_bit),
    .fg_o        (fg),
    .bg_o        (bg)
  );

  vdp_col_mux col_mux_b (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .pix_en_i (pix_en),
    .beam_i   (beam_pat),
    .regs_i   (regs),
    .pat_bit_i(pat_bit),
    .fg_i     (fg),
    .bg_i     (bg),
    .pixel_o  (pixel_o)
  );

endmodule

`default_nettype wire

// ==== verif/vdp_properties.sv ====
// Concurrent assertions on the host handshake, output blanking and interrupt reset state
`timescale 1ns/100ps
`default_nettype none

module vdp_properties
  import vdp_video_pkg::*;
(
  input wire logic   clk_i,
  input wire logic   reset_i,
  input wire logic   cpu_req_i,
  input wire logic   cpu_ack_i,
  input wire logic   int_n_i,
  input wire pixel_t pixel_i
);

  // ---------------------------------------------------------------------
  // Four-phase handshake
  // ---------------------------------------------------------------------
  // Ack only answers a pending request
  ack_rise_a: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(cpu_ack_i) |-> $past(cpu_req_i))
    else $error("cpu_ack_o rose without a pending request");

  // Ack held until the host lets go
  ack_fall_a: assert property (@(posedge clk_i) disable iff (reset_i)
    $fell(cpu_ack_i) |-> !$past(cpu_req_i))
    else $error("cpu_ack_o fell while the request was still high");

  // Blanked pixels carry color 0
  blank_col_a: assert property (@(posedge clk_i) disable iff (reset_i)
    pixel_i.blank |-> (pixel_i.col == 4'h0))
    else $error("blank pixel with nonzero color");

  // Interrupt inactive straight out of reset
  int_reset_a: assert property (@(posedge clk_i) reset_i |=> int_n_i)
    else $error("int_n_o low in the cycle after reset");

endmodule

`default_nettype wire

// ==== verif/vdp_tb.sv ====
// Testbench for vdp_core with shadow VRAM, shadow registers, pixel model and handshake driver
`timescale 1ns/100ps
`default_nettype none
`include "vdp_defines.svh"

module vdp_tb
  import vdp_cpu_pkg::*;
  import vdp_video_pkg::*;
();

  localparam int FRAME_PIX = `VDP_H_TOTAL * `VDP_V_TOTAL;
  localparam int FRAME_CLKS = 2 * FRAME_PIX;
  localparam int VRAM_SIZE = 1 << `VDP_VRAM_AW;
  // Handshake never needs more than a handful of clocks
  localparam int ACK_LIMIT = 20;
  // Longest stall of a host VRAM access behind display reads
  localparam int VRAM_WAIT_MAX = 4;

  logic       clk;
  logic       reset;
  logic       cpu_req;
  cpu_cmd_t   cpu_cmd;
  logic       cpu_ack;
  logic [7:0] cpu_rdata;
  logic       int_n;
  pixel_t     pixel;

  // Shadow state of the device
  logic [7:0] vram_model [VRAM_SIZE];
  vdp_regs_t  regs_model;

  vdp_core u_vdp_core (
    .clk_i      (clk),
    .reset_i    (reset),
    .cpu_req_i  (cpu_req),
    .cpu_cmd_i  (cpu_cmd),
    .cpu_ack_o  (cpu_ack),
    .cpu_rdata_o(cpu_rdata),
    .int_n_o    (int_n),
    .pixel_o    (pixel)
  );

  bind vdp_core vdp_properties u_properties (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .cpu_req_i(cpu_req_i),
    .cpu_ack_i(cpu_ack_o),
    .int_n_i  (int_n_o),
    .pixel_i  (pixel_o)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ---------------------------------------------------------------------
  // Helpers
  // ---------------------------------------------------------------------
  // Drive and sample point 1 ns past the rising edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERROR at %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
      $display("Verification failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t while waiting for %s", $time, what);
    $display("Verification failed");
    $fatal(1, "Wait for %s hung", what);
  endtask

  // Four-phase access returning read data and the req-to-ack delay in clocks
  task automatic cpu_access(input cpu_op_t op, input reg_idx_t index,
                            input logic [11:0] addr, input logic [7:0] data,
                            output logic [7:0] rdata, output int latency);
    int fall_cnt;
    cpu_cmd = '{op: op, index: index, addr: addr, data: data};
    cpu_req = 1'b1;
    latency = 0;
    while (cpu_ack !== 1'b1) begin
      tick();
      latency++;
      if (latency > ACK_LIMIT) report_timeout("cpu_ack_o to rise");
    end
    rdata = cpu_rdata;
    cpu_req = 1'b0;
    fall_cnt = 0;
    while (cpu_ack !== 1'b0) begin
      tick();
      fall_cnt++;
      if (fall_cnt > ACK_LIMIT) report_timeout("cpu_ack_o to fall");
    end
    // Port drops ack one clock after it sees req low
    check_value("cpu_ack_o fall delay", 1, fall_cnt);
  endtask

  task automatic reg_write(input reg_idx_t index, input logic [7:0] data);
    logic [7:0] rd;
    int         lat;
    cpu_access(OP_REG_WR, index, 12'h000, data, rd, lat);
    check_value("cpu_ack_o rise delay on register write", 2, lat);
    case (index)
      REG_CTRL: regs_model.ctrl = data;
      REG_NTB:  regs_model.ntb  = data;
      REG_PAT:  regs_model.pat  = data;
      default:  regs_model.col  = data;
    endcase
  endtask

  task automatic status_read(output logic [7:0] status);
    int lat;
    cpu_access(OP_STATUS_RD, REG_CTRL, 12'h000, 8'h00, status, lat);
    check_value("cpu_rdata_o status low bits", 0, 32'(status[6:0]));
    check_value("cpu_ack_o rise delay on status read", 2, lat);
  endtask

  task automatic vram_write(input logic [11:0] addr, input logic [7:0] data);
    logic [7:0] rd;
    int         lat;
    cpu_access(OP_VRAM_WR, REG_CTRL, addr, data, rd, lat);
    // Two-clock path plus the arbitration stall
    check_value("cpu_ack_o delay on VRAM write in bound", 1,
                32'(lat <= 2 + VRAM_WAIT_MAX));
    vram_model[addr] = data;
  endtask

  task automatic vram_read(input logic [11:0] addr, output logic [7:0] data);
    int lat;
    cpu_access(OP_VRAM_RD, REG_CTRL, addr, 8'h00, data, lat);
    // One more clock for the read data
    check_value("cpu_ack_o delay on VRAM read in bound", 1,
                32'(lat <= 3 + VRAM_WAIT_MAX));
  endtask

  // ---------------------------------------------------------------------
  // Pixel model with tile fetch and color selection
  // ---------------------------------------------------------------------
  function automatic logic [3:0] model_color(input int x, input int y);
    logic [11:0] addr;
    logic [7:0]  name;
    logic [7:0]  pat_byte;
    logic [7:0]  color;
    logic [2:0]  bit_idx;
    logic [3:0]  sel;
    if (x >= `VDP_ACT_W || y >= `VDP_ACT_H) begin
      return 4'h0;
    end
    if (!regs_model.ctrl[0]) begin
      return regs_model.col[3:0];
    end
    // Name table holds 8 tiles per row
    addr = 12'(regs_model.ntb[5:0] * 64 + (y / `VDP_TILE) * 8 + x / `VDP_TILE);
    name = vram_model[addr];
    addr = 12'(regs_model.pat[0] * 2048 + name * 8 + y % `VDP_TILE);
    pat_byte = vram_model[addr];
    // One color byte per group of 8 names
    addr = 12'(regs_model.col[7:4] * 256 + name / 8);
    color = vram_model[addr];
    bit_idx = 3'(7 - x % `VDP_TILE);
    sel = pat_byte[bit_idx] ? color[7:4] : color[3:0];
    return (sel == 4'h0) ? regs_model.col[3:0] : sel;
  endfunction

  // Checks every valid pixel over the given number of frames
  task automatic check_frames(input int frames);
    int clk_cnt;
    int seen;
    int gap;
    int x;
    int y;
    logic exp_blank;
    // Start in vertical blank so every fetch sees the current registers
    clk_cnt = 0;
    while (!(pixel.valid === 1'b1 && pixel.y == cnt_t'(`VDP_ACT_H + 3))) begin
      tick();
      clk_cnt++;
      if (clk_cnt > 2 * FRAME_CLKS) report_timeout("a pixel in vertical blank");
    end
    // Raster position of the last valid pixel
    x = int'(pixel.x);
    y = int'(pixel.y);
    clk_cnt = 0;
    seen = 0;
    gap = 0;
    while (seen < frames * FRAME_PIX) begin
      tick();
      clk_cnt++;
      gap++;
      if (clk_cnt > frames * FRAME_CLKS + 64) report_timeout("valid pixels");
      if (pixel.valid === 1'b1) begin
        seen++;
        // Next pixel in raster order
        x = x + 1;
        if (x == `VDP_H_TOTAL) begin
          x = 0;
          y = (y + 1) % `VDP_V_TOTAL;
        end
        check_value("pixel_o.valid spacing in clocks", 2, gap);
        gap = 0;
        check_value("pixel_o.x", x, 32'(pixel.x));
        check_value("pixel_o.y", y, 32'(pixel.y));
        exp_blank = (x >= `VDP_ACT_W) || (y >= `VDP_ACT_H);
        check_value($sformatf("pixel_o.blank at (%0d,%0d)", x, y),
                    32'(exp_blank), 32'(pixel.blank));
        check_value($sformatf("pixel_o.col at (%0d,%0d)", x, y),
                    32'(model_color(x, y)), 32'(pixel.col));
      end
    end
  endtask

  // ---------------------------------------------------------------------
  // Test sequence
  // ---------------------------------------------------------------------
  initial begin
    logic [7:0]  rd;
    logic [11:0] addr;
    int          clk_cnt;
    reset = 1'b1;
    cpu_req = 1'b0;
    cpu_cmd = '0;
    regs_model = '0;
    void'($urandom(42727));
    repeat (10) tick();
    reset = 1'b0;
    check_value("cpu_ack_o after reset", 0, 32'(cpu_ack));
    check_value("int_n_o after reset", 1, 32'(int_n));
    check_value("pixel_o.valid after reset", 0, 32'(pixel.valid));

    // Whole VRAM gets defined contents first
    for (int a = 0; a < VRAM_SIZE; a++) begin
      vram_write(12'(a), 8'($urandom));
    end
    repeat (200) begin
      vram_write(12'($urandom), 8'($urandom));
    end
    repeat (200) begin
      addr = 12'($urandom);
      vram_read(addr, rd);
      check_value($sformatf("cpu_rdata_o at VRAM 0x%03h", addr),
                  32'(vram_model[addr]), 32'(rd));
    end

    // Register and status timing
    repeat (16) begin
      reg_write(reg_idx_t'(2'($urandom)), 8'($urandom));
      status_read(rd);
    end

    // Random tables and backdrop with the display on
    reg_write(REG_NTB, 8'($urandom_range(0, 63)));
    reg_write(REG_PAT, 8'($urandom_range(0, 1)));
    reg_write(REG_COL, 8'($urandom));
    reg_write(REG_CTRL, 8'h01);
    check_frames(2);
    // Display off shows only the backdrop
    reg_write(REG_CTRL, 8'h00);
    check_frames(1);

    // Frame interrupt
    status_read(rd);
    reg_write(REG_CTRL, 8'h03);
    clk_cnt = 0;
    while (int_n !== 1'b0) begin
      tick();
      clk_cnt++;
      if (clk_cnt > FRAME_CLKS + 16) report_timeout("int_n_o to go low");
    end
    status_read(rd);
    check_value("cpu_rdata_o status bit 7", 1, 32'(rd[7]));
    check_value("int_n_o after status read", 1, 32'(int_n));
    reg_write(REG_CTRL, 8'h01);
    repeat (FRAME_CLKS + 16) begin
      tick();
      check_value("int_n_o with interrupt disabled", 1, 32'(int_n));
    end

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+design
design/vdp_cpu_pkg.sv
design/vdp_video_pkg.sv
design/vdp_cpu_port.sv
design/vdp_timing.sv
design/vdp_vram.sv
design/vdp_delay_line.sv
design/vdp_pattern.sv
design/vdp_col_mux.sv
design/vdp_core.sv
verif/vdp_properties.sv
verif/vdp_tb.sv

// ==== Makefile ====
# Verilator build and run for the VDP core testbench

VERILATOR ?= verilator
TOP       ?= vdp_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Verification passed

.PHONY: sim clean

# Pass only if the run prints the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
